//--- src.f
fsync_pkg.sv
fsync_req_if.sv
fsync_fifo.sv
fsync_rx.sv
fsync_cc.sv
fsync_rsp_bcast.sv
fsync_node.sv
tb_clkgen.sv
tb_checker.sv
tb_fsync_node.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_fsync_node
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_fsync_node.sv
// Testbench top, applies the barrier table to the node and models the parent
`timescale 1ns/1ps
`default_nettype none

module tb_fsync_node;
  import fsync_pkg::*;

  typedef struct {
    aggr_t      e_aggr;
    id_t        e_id;
    aggr_t      w_aggr;
    id_t        w_id;
    logic [1:0] send;
    logic       par;
    aggr_t      exp_up;
    id_t        exp_id;
    logic       bp;
    logic       nowait;
    logic       chk;
  } test_t;

  localparam int N_TESTS = 13;
  localparam int TIMEOUT_CYC = N_TESTS * 200;

  logic  clk;
  logic  rst_n;
  logic  east_req_valid, east_req_ready, west_req_valid, west_req_ready;
  aggr_t east_req_aggr, west_req_aggr, up_req_aggr;
  id_t   east_req_id, west_req_id, east_rsp_id, west_rsp_id, up_req_id, up_rsp_id;
  logic  east_rsp_valid, east_rsp_ready, west_rsp_valid, west_rsp_ready;
  logic  up_req_valid, up_req_ready, up_rsp_valid, up_rsp_ready;
  logic  test_end, all_done, bp_en, par_en;
  int    test_idx, errors, pending;
  id_t   exp_rsp;
  aggr_t exp_up;
  logic  check_last;
  id_t   par_q[$];
  test_t tests[N_TESTS];
  int    seed = 32'ha308_5057;

  tb_clkgen i_clkgen (.clk_o(clk), .rst_no(rst_n));

  fsync_node i_dut (
    .clk_i(clk), .rst_ni(rst_n),
    .east_req_valid_i(east_req_valid), .east_req_ready_o(east_req_ready),
    .east_req_aggr_i(east_req_aggr), .east_req_id_i(east_req_id),
    .west_req_valid_i(west_req_valid), .west_req_ready_o(west_req_ready),
    .west_req_aggr_i(west_req_aggr), .west_req_id_i(west_req_id),
    .east_rsp_valid_o(east_rsp_valid), .east_rsp_ready_i(east_rsp_ready),
    .east_rsp_id_o(east_rsp_id),
    .west_rsp_valid_o(west_rsp_valid), .west_rsp_ready_i(west_rsp_ready),
    .west_rsp_id_o(west_rsp_id),
    .up_req_valid_o(up_req_valid), .up_req_ready_i(up_req_ready),
    .up_req_aggr_o(up_req_aggr), .up_req_id_o(up_req_id),
    .up_rsp_valid_i(up_rsp_valid), .up_rsp_ready_o(up_rsp_ready), .up_rsp_id_i(up_rsp_id)
  );

  tb_checker i_chk (
    .clk_i(clk), .rst_ni(rst_n),
    .east_req_valid_i(east_req_valid), .east_req_ready_i(east_req_ready),
    .east_req_aggr_i(east_req_aggr), .east_req_id_i(east_req_id),
    .west_req_valid_i(west_req_valid), .west_req_ready_i(west_req_ready),
    .west_req_aggr_i(west_req_aggr), .west_req_id_i(west_req_id),
    .east_rsp_valid_i(east_rsp_valid), .east_rsp_ready_i(east_rsp_ready),
    .east_rsp_id_i(east_rsp_id),
    .west_rsp_valid_i(west_rsp_valid), .west_rsp_ready_i(west_rsp_ready),
    .west_rsp_id_i(west_rsp_id),
    .up_req_valid_i(up_req_valid), .up_req_ready_i(up_req_ready),
    .up_req_aggr_i(up_req_aggr), .up_req_id_i(up_req_id),
    .up_rsp_valid_i(up_rsp_valid), .up_rsp_ready_i(up_rsp_ready), .up_rsp_id_i(up_rsp_id),
    .test_end_i(test_end), .test_idx_i(test_idx), .all_done_i(all_done),
    .exp_rsp_i(exp_rsp), .exp_up_i(exp_up), .check_last_i(check_last),
    .errors_o(errors), .pending_o(pending)
  );

  // Fields: east mask/id, west mask/id, send, parent, up mask, rsp id, bp, nowait, chk
  task automatic load_table();
    tests[0]  = '{4'b0001, 3'd2, 4'b0001, 3'd2, 2'b11, 1'b0, 4'b0000, 3'd2, 1'b0, 1'b0, 1'b1};
    tests[1]  = '{4'b0111, 3'd5, 4'b0111, 3'd5, 2'b11, 1'b1, 4'b0011, 3'd5, 1'b0, 1'b0, 1'b1};
    tests[2]  = '{4'b0001, 3'd3, 4'b0001, 3'd3, 2'b01, 1'b0, 4'b0000, 3'd3, 1'b0, 1'b0, 1'b0};
    tests[3]  = '{4'b0001, 3'd3, 4'b0001, 3'd3, 2'b10, 1'b0, 4'b0000, 3'd3, 1'b0, 1'b0, 1'b1};
    // Four ids interleaved, matched by id in the checker
    tests[4]  = '{4'b0011, 3'd1, 4'b0011, 3'd1, 2'b01, 1'b1, 4'b0000, 3'd0, 1'b0, 1'b1, 1'b0};
    tests[5]  = '{4'b0001, 3'd4, 4'b0001, 3'd4, 2'b01, 1'b1, 4'b0000, 3'd0, 1'b0, 1'b1, 1'b0};
    tests[6]  = '{4'b1001, 3'd6, 4'b0001, 3'd4, 2'b11, 1'b1, 4'b0000, 3'd0, 1'b0, 1'b1, 1'b0};
    tests[7]  = '{4'b0001, 3'd7, 4'b0011, 3'd1, 2'b11, 1'b1, 4'b0000, 3'd0, 1'b0, 1'b1, 1'b0};
    tests[8]  = '{4'b0001, 3'd7, 4'b1001, 3'd6, 2'b10, 1'b1, 4'b0000, 3'd0, 1'b0, 1'b1, 1'b0};
    tests[9]  = '{4'b0001, 3'd7, 4'b0001, 3'd7, 2'b10, 1'b1, 4'b0000, 3'd7, 1'b0, 1'b0, 1'b0};
    tests[10] = '{4'b0101, 3'd0, 4'b0101, 3'd0, 2'b11, 1'b1, 4'b0010, 3'd0, 1'b1, 1'b0, 1'b1};
    tests[11] = '{4'b0001, 3'd6, 4'b0001, 3'd6, 2'b11, 1'b0, 4'b0000, 3'd6, 1'b1, 1'b0, 1'b1};
    tests[12] = '{4'b1111, 3'd2, 4'b1111, 3'd2, 2'b11, 1'b1, 4'b0111, 3'd2, 1'b1, 1'b0, 1'b1};
  endtask

  // Offers the entry's child requests until each one is taken
  task automatic send_reqs(input test_t t);
    logic e_pend;
    logic w_pend;
    logic e_hs;
    logic w_hs;
    e_pend = t.send[0];
    w_pend = t.send[1];
    east_req_valid = e_pend;
    east_req_aggr = t.e_aggr;
    east_req_id = t.e_id;
    west_req_valid = w_pend;
    west_req_aggr = t.w_aggr;
    west_req_id = t.w_id;
    while (e_pend || w_pend) begin
      @(negedge clk);
      e_hs = e_pend && east_req_ready;
      w_hs = w_pend && west_req_ready;
      @(posedge clk);
      #1;
      if (e_hs) begin
        e_pend = 1'b0;
        east_req_valid = 1'b0;
      end
      if (w_hs) begin
        w_pend = 1'b0;
        west_req_valid = 1'b0;
      end
    end
  endtask

  // Random stalls on the response and up request ports
  always @(posedge clk) begin
    #1;
    east_rsp_ready = !bp_en || (($random(seed) & 3) != 0);
    west_rsp_ready = !bp_en || (($random(seed) & 3) != 0);
    up_req_ready = !bp_en || (($random(seed) & 3) != 0);
  end

  always @(negedge clk) begin
    if (rst_n && up_req_valid && up_req_ready) par_q.push_back(up_req_id);
  end

  // Parent answers each up request after a random delay
  initial begin
    int   delay;
    logic hs;
    forever begin
      @(posedge clk);
      if (par_en && par_q.size() != 0) begin
        delay = 1 + ($random(seed) & 7);
        repeat (delay) @(posedge clk);
        #1;
        up_rsp_id = par_q.pop_front();
        up_rsp_valid = 1'b1;
        do begin
          @(negedge clk);
          hs = up_rsp_ready;
          @(posedge clk);
        end while (!hs);
        #1 up_rsp_valid = 1'b0;
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("Timeout after %0d cycles, %0d items still outstanding", TIMEOUT_CYC, pending);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    east_req_valid = 1'b0;
    east_req_aggr = '0;
    east_req_id = '0;
    west_req_valid = 1'b0;
    west_req_aggr = '0;
    west_req_id = '0;
    east_rsp_ready = 1'b1;
    west_rsp_ready = 1'b1;
    up_req_ready = 1'b1;
    up_rsp_valid = 1'b0;
    up_rsp_id = '0;
    bp_en = 1'b0;
    par_en = 1'b0;
    test_end = 1'b0;
    all_done = 1'b0;
    test_idx = 0;
    exp_rsp = '0;
    exp_up = '0;
    check_last = 1'b0;
    load_table();
    @(posedge rst_n);
    repeat (2) @(posedge clk);
    #1;
    for (int i = 0; i < N_TESTS; i++) begin
      test_idx = i;
      bp_en = tests[i].bp;
      par_en = tests[i].par;
      exp_rsp = tests[i].exp_id;
      exp_up = tests[i].exp_up;
      check_last = tests[i].chk;
      send_reqs(tests[i]);
      if (!tests[i].nowait) begin
        while (pending != 0) @(posedge clk);
        // Idle cycles catch stray responses
        repeat (4) @(posedge clk);
        #1;
      end
      test_end = 1'b1;
      @(posedge clk);
      #1 test_end = 1'b0;
    end
    all_done = 1'b1;
    @(posedge clk);
    #1 all_done = 1'b0;
    @(posedge clk);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_checker.sv
// Testbench monitor, predicts joins, up requests and responses by the barrier rules, counts errors
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             east_req_valid_i,
  input  wire logic             east_req_ready_i,
  input  wire fsync_pkg::aggr_t east_req_aggr_i,
  input  wire fsync_pkg::id_t   east_req_id_i,
  input  wire logic             west_req_valid_i,
  input  wire logic             west_req_ready_i,
  input  wire fsync_pkg::aggr_t west_req_aggr_i,
  input  wire fsync_pkg::id_t   west_req_id_i,
  input  wire logic             east_rsp_valid_i,
  input  wire logic             east_rsp_ready_i,
  input  wire fsync_pkg::id_t   east_rsp_id_i,
  input  wire logic             west_rsp_valid_i,
  input  wire logic             west_rsp_ready_i,
  input  wire fsync_pkg::id_t   west_rsp_id_i,
  input  wire logic             up_req_valid_i,
  input  wire logic             up_req_ready_i,
  input  wire fsync_pkg::aggr_t up_req_aggr_i,
  input  wire fsync_pkg::id_t   up_req_id_i,
  input  wire logic             up_rsp_valid_i,
  input  wire logic             up_rsp_ready_i,
  input  wire fsync_pkg::id_t   up_rsp_id_i,
  input  wire logic             test_end_i,
  input  wire logic [31:0]      test_idx_i,
  input  wire logic             all_done_i,
  input  wire fsync_pkg::id_t   exp_rsp_i,
  input  wire fsync_pkg::aggr_t exp_up_i,
  input  wire logic             check_last_i,
  output int                    errors_o,
  output int                    pending_o
);
  import fsync_pkg::*;

  // Model of the node's join state per id
  logic  arr_e [N_IDS];
  logic  arr_w [N_IDS];
  logic  up_exp [N_IDS];
  aggr_t up_mask [N_IDS];
  int    rsp_e [N_IDS];
  int    rsp_w [N_IDS];
  int    test_err;
  int    tests_run;
  int    tests_bad;
  logic  hold_q;
  aggr_t hold_aggr;
  id_t   hold_id;
  logic  rst_prev;
  id_t   last_rsp;
  aggr_t last_up;

  task automatic hex_mismatch(input string name, input logic [7:0] got, input logic [7:0] exp);
    $display("[FAIL] %s got %h expected %h", name, got, exp);
    errors_o++;
    test_err++;
  endtask

  task automatic event_error(input string text);
    $display("Error: %s", text);
    errors_o++;
    test_err++;
  endtask

  // Second arrival decides between local and upward completion
  task automatic note_arrival(input id_t id, input aggr_t mask, input logic east);
    if (east) arr_e[id] = 1'b1;
    else arr_w[id] = 1'b1;
    if (arr_e[id] && arr_w[id]) begin
      arr_e[id] = 1'b0;
      arr_w[id] = 1'b0;
      if (mask[AGGR_W-1:1] == '0) begin
        rsp_e[id]++;
        rsp_w[id]++;
        pending_o += 2;
      end else begin
        up_exp[id] = 1'b1;
        up_mask[id] = mask >> 1;
        // One up request now, two responses once the parent answers
        pending_o += 3;
      end
    end
  endtask

  initial begin
    errors_o = 0;
    pending_o = 0;
    test_err = 0;
    tests_run = 0;
    tests_bad = 0;
    hold_q = 1'b0;
    rst_prev = 1'b0;
    last_rsp = '0;
    last_up = '0;
    for (int i = 0; i < N_IDS; i++) begin
      arr_e[i] = 1'b0;
      arr_w[i] = 1'b0;
      up_exp[i] = 1'b0;
      rsp_e[i] = 0;
      rsp_w[i] = 0;
    end
  end

  // Everything is sampled mid-cycle, where inputs and outputs are settled
  always @(negedge clk_i) begin
    if (!rst_ni || !rst_prev) begin
      if (east_rsp_valid_i) hex_mismatch("east_rsp_valid_o", 8'(east_rsp_valid_i), 8'h0);
      if (west_rsp_valid_i) hex_mismatch("west_rsp_valid_o", 8'(west_rsp_valid_i), 8'h0);
      if (up_req_valid_i) hex_mismatch("up_req_valid_o", 8'(up_req_valid_i), 8'h0);
    end
    if (rst_ni) begin
      if (hold_q) begin
        if (!up_req_valid_i) event_error("up request valid dropped before it was taken");
        if (up_req_aggr_i != hold_aggr)
          hex_mismatch("up_req_aggr_o", 8'(up_req_aggr_i), 8'(hold_aggr));
        if (up_req_id_i != hold_id) hex_mismatch("up_req_id_o", 8'(up_req_id_i), 8'(hold_id));
      end
      hold_q = up_req_valid_i && !up_req_ready_i;
      hold_aggr = up_req_aggr_i;
      hold_id = up_req_id_i;
      if (east_req_valid_i && east_req_ready_i) note_arrival(east_req_id_i, east_req_aggr_i, 1'b1);
      if (west_req_valid_i && west_req_ready_i) note_arrival(west_req_id_i, west_req_aggr_i, 1'b0);
      if (up_req_valid_i && up_req_ready_i) begin
        if (!up_exp[up_req_id_i]) begin
          event_error($sformatf("up request for id %0d was not due", up_req_id_i));
        end else begin
          if (up_req_aggr_i != up_mask[up_req_id_i])
            hex_mismatch("up_req_aggr_o", 8'(up_req_aggr_i), 8'(up_mask[up_req_id_i]));
          up_exp[up_req_id_i] = 1'b0;
          pending_o--;
          last_up = up_req_aggr_i;
        end
      end
      if (up_rsp_valid_i && up_rsp_ready_i) begin
        rsp_e[up_rsp_id_i]++;
        rsp_w[up_rsp_id_i]++;
      end
      if (east_rsp_valid_i && east_rsp_ready_i) begin
        if (rsp_e[east_rsp_id_i] == 0) begin
          event_error($sformatf("east got a response for id %0d that was not due", east_rsp_id_i));
        end else begin
          rsp_e[east_rsp_id_i]--;
          pending_o--;
        end
        last_rsp = east_rsp_id_i;
      end
      if (west_rsp_valid_i && west_rsp_ready_i) begin
        if (rsp_w[west_rsp_id_i] == 0) begin
          event_error($sformatf("west got a response for id %0d that was not due", west_rsp_id_i));
        end else begin
          rsp_w[west_rsp_id_i]--;
          pending_o--;
        end
      end
    end
    rst_prev = rst_ni;
    if (test_end_i) begin
      if (check_last_i && last_rsp != exp_rsp_i)
        hex_mismatch("east_rsp_id_o", 8'(last_rsp), 8'(exp_rsp_i));
      if (check_last_i && exp_up_i != '0 && last_up != exp_up_i)
        hex_mismatch("up_req_aggr_o", 8'(last_up), 8'(exp_up_i));
      $display("test %0d finished with %0d errors", test_idx_i, test_err);
      tests_run++;
      if (test_err != 0) tests_bad++;
      test_err = 0;
    end
    if (all_done_i) begin
      if (pending_o != 0) event_error("responses or up requests still missing at the end");
      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_bad, errors_o);
    end
  end

endmodule

`default_nettype wire

//--- tb_clkgen.sv
// Testbench clock and reset source, 20 ns clock with reset held low for the first 10 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  localparam time HALF_PERIOD = 10ns;
  localparam int unsigned RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- fsync_node.sv
// Top level of the 1D barrier sync node with east/west child ports and one parent port
`timescale 1ns/1ps
`default_nettype none

module fsync_node (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             east_req_valid_i,
  output logic                  east_req_ready_o,
  input  wire fsync_pkg::aggr_t east_req_aggr_i,
  input  wire fsync_pkg::id_t   east_req_id_i,
  input  wire logic             west_req_valid_i,
  output logic                  west_req_ready_o,
  input  wire fsync_pkg::aggr_t west_req_aggr_i,
  input  wire fsync_pkg::id_t   west_req_id_i,
  output logic                  east_rsp_valid_o,
  input  wire logic             east_rsp_ready_i,
  output fsync_pkg::id_t        east_rsp_id_o,
  output logic                  west_rsp_valid_o,
  input  wire logic             west_rsp_ready_i,
  output fsync_pkg::id_t        west_rsp_id_o,
  output logic                  up_req_valid_o,
  input  wire logic             up_req_ready_i,
  output fsync_pkg::aggr_t      up_req_aggr_o,
  output fsync_pkg::id_t        up_req_id_o,
  input  wire logic             up_rsp_valid_i,
  output logic                  up_rsp_ready_o,
  input  wire fsync_pkg::id_t   up_rsp_id_i
);
  import fsync_pkg::*;

  // Local completions toward the broadcast stage
  logic local_valid;
  logic local_ready;
  id_t  local_id;

  fsync_req_if east_req_if ();
  fsync_req_if west_req_if ();

  fsync_rx i_east_rx (
    .clk_i,
    .rst_ni,
    .req_valid_i ( east_req_valid_i ),
    .req_ready_o ( east_req_ready_o ),
    .req_aggr_i  ( east_req_aggr_i  ),
    .req_id_i    ( east_req_id_i    ),
    .req         ( east_req_if      )
  );

  fsync_rx i_west_rx (
    .clk_i,
    .rst_ni,
    .req_valid_i ( west_req_valid_i ),
    .req_ready_o ( west_req_ready_o ),
    .req_aggr_i  ( west_req_aggr_i  ),
    .req_id_i    ( west_req_id_i    ),
    .req         ( west_req_if      )
  );

  fsync_cc i_cc (
    .clk_i,
    .rst_ni,
    .east_req       ( east_req_if    ),
    .west_req       ( west_req_if    ),
    .up_req_valid_o ( up_req_valid_o ),
    .up_req_ready_i ( up_req_ready_i ),
    .up_req_aggr_o  ( up_req_aggr_o  ),
    .up_req_id_o    ( up_req_id_o    ),
    .local_valid_o  ( local_valid    ),
    .local_ready_i  ( local_ready    ),
    .local_id_o     ( local_id       )
  );

  fsync_rsp_bcast i_rsp_bcast (
    .clk_i,
    .rst_ni,
    .local_valid_i    ( local_valid      ),
    .local_ready_o    ( local_ready      ),
    .local_id_i       ( local_id         ),
    .up_rsp_valid_i   ( up_rsp_valid_i   ),
    .up_rsp_ready_o   ( up_rsp_ready_o   ),
    .up_rsp_id_i      ( up_rsp_id_i      ),
    .east_rsp_valid_o ( east_rsp_valid_o ),
    .east_rsp_ready_i ( east_rsp_ready_i ),
    .east_rsp_id_o    ( east_rsp_id_o    ),
    .west_rsp_valid_o ( west_rsp_valid_o ),
    .west_rsp_ready_i ( west_rsp_ready_i ),
    .west_rsp_id_o    ( west_rsp_id_o    )
  );

endmodule

`default_nettype wire

//--- fsync_rsp_bcast.sv
// Picks a local or parent response and delivers it once to each child
`timescale 1ns/1ps
`default_nettype none

module fsync_rsp_bcast (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,
  input  wire logic           local_valid_i,
  output logic                local_ready_o,
  input  wire fsync_pkg::id_t local_id_i,
  input  wire logic           up_rsp_valid_i,
  output logic                up_rsp_ready_o,
  input  wire fsync_pkg::id_t up_rsp_id_i,
  output logic                east_rsp_valid_o,
  input  wire logic           east_rsp_ready_i,
  output fsync_pkg::id_t      east_rsp_id_o,
  output logic                west_rsp_valid_o,
  input  wire logic           west_rsp_ready_i,
  output fsync_pkg::id_t      west_rsp_id_o
);
  import fsync_pkg::*;

  logic       up_vld_q;
  id_t        up_id_q;
  logic       busy_q;
  logic       src_up_q;
  // Bit 0 east, bit 1 west
  logic [1:0] taken_q;
  logic [1:0] taken_d;
  logic       cur_up;
  logic       cur_valid;
  id_t        cur_id;
  logic       pop;

  // Parent response lands in a one-entry register
  assign up_rsp_ready_o = !up_vld_q;

  // Parent wins a fresh selection, a started one is kept
  assign cur_up    = busy_q ? src_up_q : up_vld_q;
  assign cur_valid = cur_up ? up_vld_q : local_valid_i;
  assign cur_id    = cur_up ? up_id_q : local_id_i;

  assign east_rsp_valid_o = cur_valid && !taken_q[0];
  assign west_rsp_valid_o = cur_valid && !taken_q[1];
  assign east_rsp_id_o    = cur_id;
  assign west_rsp_id_o    = cur_id;

  assign taken_d = taken_q | {west_rsp_valid_o && west_rsp_ready_i,
                              east_rsp_valid_o && east_rsp_ready_i};
  // Pop once both children have their copy
  assign pop           = cur_valid && (&taken_d);
  assign local_ready_o = pop && !cur_up;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      up_vld_q <= 1'b0;
      busy_q   <= 1'b0;
      src_up_q <= 1'b0;
      taken_q  <= '0;
    end else begin
      if (up_rsp_valid_i && up_rsp_ready_o) begin
        up_vld_q <= 1'b1;
      end else if (pop && cur_up) begin
        up_vld_q <= 1'b0;
      end
      busy_q   <= cur_valid && !pop;
      src_up_q <= cur_up;
      taken_q  <= pop ? '0 : taken_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (up_rsp_valid_i && up_rsp_ready_o) begin
      up_id_q <= up_rsp_id_i;
    end
  end

  // Selected source holds its response until both children took it
  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cur_valid && !pop |=> cur_valid && $stable(cur_id));

endmodule

`default_nettype wire

//--- fsync_cc.sv
// Control core, joins east and west arrivals per id and queues local and upward completions
`timescale 1ns/1ps
`default_nettype none

module fsync_cc (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  fsync_req_if.dst         east_req,
  fsync_req_if.dst         west_req,
  output logic             up_req_valid_o,
  input  wire logic        up_req_ready_i,
  output fsync_pkg::aggr_t up_req_aggr_o,
  output fsync_pkg::id_t   up_req_id_o,
  output logic             local_valid_o,
  input  wire logic        local_ready_i,
  output fsync_pkg::id_t   local_id_o
);
  import fsync_pkg::*;

  // Register file: arrival bits and local flag per barrier id
  logic [N_IDS-1:0] arr_e_q;
  logic [N_IDS-1:0] arr_w_q;
  logic [N_IDS-1:0] local_q;
  // Set when west goes first on the next tie
  logic             rr_q;

  logic             e_ok;
  logic             w_ok;
  logic             grant_e;
  logic             grant_w;
  id_t              sel_id;
  aggr_t            sel_aggr;
  logic             sel_local;
  logic             sel_done;
  logic             lq_push;
  logic             lq_ready;
  logic             uq_push;
  logic             uq_ready;
  logic [UP_W-1:0]  up_data;

  // Refused while already waiting on this id or the completion queue is full
  assign e_ok = east_req.valid && !arr_e_q[east_req.id] &&
                (!arr_w_q[east_req.id] || (local_q[east_req.id] ? lq_ready : uq_ready));
  assign w_ok = west_req.valid && !arr_w_q[west_req.id] &&
                (!arr_e_q[west_req.id] || (local_q[west_req.id] ? lq_ready : uq_ready));

  assign grant_e = e_ok && (!w_ok || !rr_q);
  assign grant_w = w_ok && !grant_e;

  assign east_req.ready = grant_e;
  assign west_req.ready = grant_w;

  assign sel_id    = grant_e ? east_req.id : west_req.id;
  assign sel_aggr  = grant_e ? east_req.aggr : west_req.aggr;
  assign sel_local = grant_e ? east_req.is_local : west_req.is_local;

  // Second arrival closes the join
  assign sel_done = (grant_e && arr_w_q[east_req.id]) || (grant_w && arr_e_q[west_req.id]);
  assign lq_push  = sel_done && local_q[sel_id];
  assign uq_push  = sel_done && !local_q[sel_id];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arr_e_q <= '0;
      arr_w_q <= '0;
      local_q <= '0;
      rr_q    <= 1'b0;
    end else begin
      if (sel_done) begin
        arr_e_q[sel_id] <= 1'b0;
        arr_w_q[sel_id] <= 1'b0;
      end else if (grant_e || grant_w) begin
        arr_e_q[sel_id] <= arr_e_q[sel_id] | grant_e;
        arr_w_q[sel_id] <= arr_w_q[sel_id] | grant_w;
        local_q[sel_id] <= sel_local;
      end
      if (grant_e) begin
        rr_q <= 1'b1;
      end else if (grant_w) begin
        rr_q <= 1'b0;
      end
    end
  end

  fsync_fifo #(
    .DEPTH  ( FIFO_DEPTH ),
    .data_t ( id_t       )
  ) i_local_q (
    .clk_i,
    .rst_ni,
    .push_valid_i ( lq_push       ),
    .push_ready_o ( lq_ready      ),
    .push_data_i  ( sel_id        ),
    .pop_valid_o  ( local_valid_o ),
    .pop_ready_i  ( local_ready_i ),
    .pop_data_o   ( local_id_o    )
  );

  fsync_fifo #(
    .DEPTH  ( FIFO_DEPTH       ),
    .data_t ( logic [UP_W-1:0] )
  ) i_up_q (
    .clk_i,
    .rst_ni,
    .push_valid_i ( uq_push            ),
    .push_ready_o ( uq_ready           ),
    .push_data_i  ( {sel_aggr, sel_id} ),
    .pop_valid_o  ( up_req_valid_o     ),
    .pop_ready_i  ( up_req_ready_i     ),
    .pop_data_o   ( up_data            )
  );

  assign {up_req_aggr_o, up_req_id_o} = up_data;

  // East and west classify the same barrier the same way
  a_local_agree: assert property (@(posedge clk_i) disable iff (!rst_ni)
    grant_e && arr_w_q[east_req.id] |-> east_req.is_local == local_q[east_req.id]);

endmodule

`default_nettype wire

//--- fsync_rx.sv
// Child request queue, classifies each barrier request as local or propagated
`timescale 1ns/1ps
`default_nettype none

module fsync_rx (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             req_valid_i,
  output logic                  req_ready_o,
  input  wire fsync_pkg::aggr_t req_aggr_i,
  input  wire fsync_pkg::id_t   req_id_i,
  fsync_req_if.src              req
);
  import fsync_pkg::*;

  logic             is_local;
  logic [REQ_W-1:0] push_data;
  logic [REQ_W-1:0] pop_data;

  // No level above this one in the mask
  assign is_local = ~|req_aggr_i[AGGR_W-1:1];

  // Parent sees the mask one level down
  assign push_data = {is_local, req_aggr_i >> 1, req_id_i};

  fsync_fifo #(
    .DEPTH  ( FIFO_DEPTH         ),
    .data_t ( logic [REQ_W-1:0]  )
  ) i_fifo (
    .clk_i,
    .rst_ni,
    .push_valid_i ( req_valid_i ),
    .push_ready_o ( req_ready_o ),
    .push_data_i  ( push_data   ),
    .pop_valid_o  ( req.valid   ),
    .pop_ready_i  ( req.ready   ),
    .pop_data_o   ( pop_data    )
  );

  assign {req.is_local, req.aggr, req.id} = pop_data;

  // Children only join barriers that include their own level
  a_bit0_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && req_ready_o |-> req_aggr_i[0]);

endmodule

`default_nettype wire

//--- fsync_fifo.sv
// Registered valid/ready circular queue, used for child requests and for completions
`timescale 1ns/1ps
`default_nettype none

module fsync_fifo #(
  parameter int unsigned DEPTH = fsync_pkg::FIFO_DEPTH,
  parameter type data_t = logic
) (
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  input  wire logic   push_valid_i,
  output logic        push_ready_o,
  input  wire data_t  push_data_i,
  output logic        pop_valid_o,
  input  wire logic   pop_ready_i,
  output data_t       pop_data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  data_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign do_push      = push_valid_i && push_ready_o;
  assign do_pop       = pop_valid_o && pop_ready_i;
  assign pop_data_o   = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // A push refused by a full queue stays offered with the same data
  a_push_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_valid_i && !push_ready_o |=> push_valid_i && $stable(push_data_i));

endmodule

`default_nettype wire

//--- fsync_req_if.sv
// Carries one classified barrier request from an RX queue into the control core
`timescale 1ns/1ps
`default_nettype none

interface fsync_req_if;
  import fsync_pkg::*;

  logic  valid;
  logic  ready;
  // Mask already shifted for the parent
  aggr_t aggr;
  id_t   id;
  // High when this level closes the barrier
  logic  is_local;

  modport src (output valid, input ready, output aggr, output id, output is_local);
  modport dst (input valid, output ready, input aggr, input id, input is_local);

endinterface

`default_nettype wire

//--- fsync_pkg.sv
// Shared widths, queue depth and types of the barrier sync node, imported by all RTL files
`default_nettype none

package fsync_pkg;

  // Aggregation mask, bit 0 is this node's level
  localparam int unsigned AGGR_W = 4;
  localparam int unsigned ID_W = 3;

  // One register file entry per barrier id
  localparam int unsigned N_IDS = 2 ** ID_W;

  // Default depth of every queue
  localparam int unsigned FIFO_DEPTH = 2;

  // Upward request word {aggr, id}
  localparam int unsigned UP_W = AGGR_W + ID_W;
  // Classified request word {local, aggr, id}
  localparam int unsigned REQ_W = UP_W + 1;

  typedef logic [AGGR_W-1:0] aggr_t;
  typedef logic [ID_W-1:0] id_t;

endpackage

`default_nettype wire
